// ==== src/roll_grid_pkg.sv ====
package roll_grid_pkg;

    ////////////////////////////////////////
    // Grid limits and widths.
    ////////////////////////////////////////

    localparam int MAX_COLS = 64;
    localparam int MAX_ROWS = 64;

    localparam int COUNT_WIDTH = 2;   // Left + self + right, 0 to 3.
    localparam int RESULT_WIDTH = 13;

    // A roll is accessible with at most this many neighbouring rolls.
    localparam int MAX_ADJACENT_FOR_ACCESS = 3;

    ////////////////////////////////////////
    // Shared types.
    ////////////////////////////////////////

    typedef logic [$clog2(MAX_COLS)-1:0] col_index_t;
    typedef logic [$clog2(MAX_ROWS)-1:0] row_index_t;
    typedef logic [COUNT_WIDTH-1:0] roll_count_t;
    typedef logic [RESULT_WIDTH-1:0] access_count_t;

endpackage

// ==== src/roll_row_sum.sv ====
module roll_row_sum (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cell_valid,
    input  logic                      cell_roll,
    input  logic                      cell_row_last,
    input  logic                      cell_grid_last,
    output logic                      sum_valid,
    output logic                      sum_row_last,
    output logic                      sum_grid_last,
    output logic                      sum_mask,
    output roll_grid_pkg::roll_count_t sum_count
);

    import roll_grid_pkg::*;

    logic have_cur;      // A cell is held, waiting for its right neighbour.
    logic cur_roll;
    logic cur_row_last;
    logic cur_grid_last;
    logic left_roll;
    logic right_roll;

    // The held cell goes out with the next strobe, or on its own after a row end.
    assign sum_valid = have_cur && (cell_valid || cur_row_last);

    assign right_roll = cur_row_last ? 1'b0 : cell_roll; // Nothing right of the row end.

    assign sum_mask      = cur_roll;
    assign sum_row_last  = cur_row_last;
    assign sum_grid_last = cur_grid_last;
    assign sum_count     = roll_count_t'(left_roll) + roll_count_t'(cur_roll)
                         + roll_count_t'(right_roll);

    always_ff @(posedge clk) begin
        if (rst) begin
            have_cur  <= 1'b0;
            left_roll <= 1'b0;
        end else begin
            if (sum_valid) begin
                // History restarts at each row end.
                left_roll <= cur_row_last ? 1'b0 : cur_roll;
            end
            if (cell_valid) begin
                have_cur <= 1'b1;
            end else if (sum_valid) begin
                have_cur <= 1'b0; // Flushed the row's last cell.
            end
        end
    end

    // Payload of the held cell.
    always_ff @(posedge clk) begin
        if (cell_valid) begin
            cur_roll      <= cell_roll;
            cur_row_last  <= cell_row_last;
            cur_grid_last <= cell_grid_last;
        end
    end

endmodule

// ==== src/row_line_store.sv ====
module row_line_store #(
    parameter type entry_t = logic
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       wr_en,
    input  logic                                       shift,
    input  roll_grid_pkg::col_index_t                  wr_col,
    input  entry_t                                     wr_data,
    output entry_t [roll_grid_pkg::MAX_COLS-1:0]       upper_row,
    output entry_t [roll_grid_pkg::MAX_COLS-1:0]       center_row
);

    import roll_grid_pkg::*;

    entry_t [MAX_COLS-1:0] lower_row;
    entry_t [MAX_COLS-1:0] lower_next;

    // Lower row including this cycle's write, so a shift keeps the last entry.
    always_comb begin
        lower_next = lower_row;
        if (wr_en) begin
            lower_next[wr_col] = wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lower_row  <= '0;
            center_row <= '0;
            upper_row  <= '0;
        end else begin
            lower_row <= lower_next;
            if (shift) begin
                upper_row  <= center_row;
                center_row <= lower_next;
            end
        end
    end

endmodule

// ==== src/row_window.sv ====
module row_window (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 sum_valid,
    input  logic                                                 sum_row_last,
    input  logic                                                 sum_grid_last,
    input  logic                                                 sum_mask,
    input  roll_grid_pkg::roll_count_t                           sum_count,
    output logic                                                 win_valid,
    output logic                                                 win_row_last,
    output logic                                                 win_grid_last,
    output logic                                                 lower_mask,
    output roll_grid_pkg::col_index_t                            win_col,
    output roll_grid_pkg::row_index_t                            win_row,
    output roll_grid_pkg::roll_count_t                           lower_count,
    output roll_grid_pkg::roll_count_t [roll_grid_pkg::MAX_COLS-1:0] upper_counts,
    output roll_grid_pkg::roll_count_t [roll_grid_pkg::MAX_COLS-1:0] center_counts,
    output logic [roll_grid_pkg::MAX_COLS-1:0]                   center_masks
);

    import roll_grid_pkg::*;

    col_index_t col_idx;
    row_index_t row_idx;
    logic       row_shift;

    assign row_shift = sum_valid && sum_row_last;

    ////////////////////////////////////////
    // Position tracking.
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            col_idx <= '0;
            row_idx <= '0;
        end else if (sum_valid) begin
            col_idx <= sum_row_last ? '0 : col_idx + col_index_t'(1);
            if (sum_row_last) begin
                row_idx <= sum_grid_last ? '0 : row_idx + row_index_t'(1);
            end
        end
    end

    ////////////////////////////////////////
    // Row stores.
    ////////////////////////////////////////

    row_line_store #(.entry_t(roll_count_t)) count_store (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (sum_valid),
        .shift      (row_shift),
        .wr_col     (col_idx),
        .wr_data    (sum_count),
        .upper_row  (upper_counts),
        .center_row (center_counts)
    );

    row_line_store #(.entry_t(logic)) mask_store (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (sum_valid),
        .shift      (row_shift),
        .wr_col     (col_idx),
        .wr_data    (sum_mask),
        .upper_row  (),            // Only the centre masks are judged.
        .center_row (center_masks)
    );

    // Current entry, tagged with its position.
    assign win_valid     = sum_valid;
    assign win_row_last  = sum_row_last;
    assign win_grid_last = sum_grid_last;
    assign win_col       = col_idx;
    assign win_row       = row_idx;
    assign lower_count   = sum_count;
    assign lower_mask    = sum_mask;

endmodule

// ==== src/accessible_roll_counter.sv ====
module accessible_roll_counter (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 win_valid,
    input  logic                                                 win_row_last,
    input  logic                                                 win_grid_last,
    input  logic                                                 lower_mask,
    input  roll_grid_pkg::col_index_t                            win_col,
    input  roll_grid_pkg::row_index_t                            win_row,
    input  roll_grid_pkg::roll_count_t                           lower_count,
    input  roll_grid_pkg::roll_count_t [roll_grid_pkg::MAX_COLS-1:0] upper_counts,
    input  roll_grid_pkg::roll_count_t [roll_grid_pkg::MAX_COLS-1:0] center_counts,
    input  logic [roll_grid_pkg::MAX_COLS-1:0]                   center_masks,
    output roll_grid_pkg::access_count_t                         access_count,
    output logic                                                 count_valid,
    output logic                                                 grid_done
);

    import roll_grid_pkg::*;

    localparam logic [3:0] WINDOW_LIMIT = 4'(MAX_ADJACENT_FOR_ACCESS + 1); // Self included.

    roll_count_t   upper_cnt;
    roll_count_t   center_cnt;
    logic          center_mask;
    logic [3:0]    window_sum;
    logic [3:0]    edge_sum;
    logic          judge;
    logic          center_ok;
    logic          lower_ok;
    logic          fresh_grid;  // Next judged column restarts the count.
    access_count_t row_pending; // Lower-row hits, in case this row is the last.
    access_count_t base_count;
    access_count_t final_add;

    ////////////////////////////////////////
    // Window at the current column.
    ////////////////////////////////////////

    always_comb begin
        upper_cnt   = (win_row == row_index_t'(1)) ? '0 : upper_counts[win_col]; // No row above.
        center_cnt  = center_counts[win_col];
        center_mask = center_masks[win_col];
    end

    assign window_sum = 4'(upper_cnt) + 4'(center_cnt) + 4'(lower_count);
    assign edge_sum   = 4'(center_cnt) + 4'(lower_count); // Lower cell as the final row.

    assign judge     = win_valid && (win_row != '0);
    assign center_ok = center_mask && (window_sum <= WINDOW_LIMIT);
    assign lower_ok  = lower_mask && (edge_sum <= WINDOW_LIMIT);

    // The grid end is only known at its last cell, so the final row is settled there.
    assign final_add  = (win_grid_last && win_row_last)
                      ? row_pending + access_count_t'(lower_ok) : '0;
    assign base_count = fresh_grid ? '0 : access_count;

    ////////////////////////////////////////
    // Accumulation.
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            access_count <= '0;
            count_valid  <= 1'b0;
            grid_done    <= 1'b0;
            fresh_grid   <= 1'b1;
            row_pending  <= '0;
        end else begin
            count_valid <= judge;
            grid_done   <= win_valid && win_grid_last;

            if (win_valid && win_row_last) begin
                row_pending <= '0;
            end else if (judge) begin
                row_pending <= row_pending + access_count_t'(lower_ok);
            end

            if (judge) begin
                access_count <= base_count + access_count_t'(center_ok) + final_add;
                fresh_grid   <= 1'b0;
            end
            if (win_valid && win_grid_last) begin
                fresh_grid <= 1'b1; // Total holds until the next grid judges.
            end
        end
    end

endmodule

// ==== src/roll_access_top.sv ====
module roll_access_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cell_valid,
    input  logic                         cell_roll,
    input  logic                         cell_row_last,
    input  logic                         cell_grid_last,
    output roll_grid_pkg::access_count_t access_count,
    output logic                         count_valid,
    output logic                         grid_done
);

    import roll_grid_pkg::*;

    // Row stage to window stage.
    logic        sum_valid;
    logic        sum_row_last;
    logic        sum_grid_last;
    logic        sum_mask;
    roll_count_t sum_count;

    // Window stage to counter.
    logic                        win_valid;
    logic                        win_row_last;
    logic                        win_grid_last;
    logic                        lower_mask;
    col_index_t                  win_col;
    row_index_t                  win_row;
    roll_count_t                 lower_count;
    roll_count_t [MAX_COLS-1:0]  upper_counts;
    roll_count_t [MAX_COLS-1:0]  center_counts;
    logic [MAX_COLS-1:0]         center_masks;

    roll_row_sum row_sum (
        .clk            (clk),
        .rst            (rst),
        .cell_valid     (cell_valid),
        .cell_roll      (cell_roll),
        .cell_row_last  (cell_row_last),
        .cell_grid_last (cell_grid_last),
        .sum_valid      (sum_valid),
        .sum_row_last   (sum_row_last),
        .sum_grid_last  (sum_grid_last),
        .sum_mask       (sum_mask),
        .sum_count      (sum_count)
    );

    row_window window (
        .clk           (clk),
        .rst           (rst),
        .sum_valid     (sum_valid),
        .sum_row_last  (sum_row_last),
        .sum_grid_last (sum_grid_last),
        .sum_mask      (sum_mask),
        .sum_count     (sum_count),
        .win_valid     (win_valid),
        .win_row_last  (win_row_last),
        .win_grid_last (win_grid_last),
        .lower_mask    (lower_mask),
        .win_col       (win_col),
        .win_row       (win_row),
        .lower_count   (lower_count),
        .upper_counts  (upper_counts),
        .center_counts (center_counts),
        .center_masks  (center_masks)
    );

    accessible_roll_counter counter (
        .clk           (clk),
        .rst           (rst),
        .win_valid     (win_valid),
        .win_row_last  (win_row_last),
        .win_grid_last (win_grid_last),
        .lower_mask    (lower_mask),
        .win_col       (win_col),
        .win_row       (win_row),
        .lower_count   (lower_count),
        .upper_counts  (upper_counts),
        .center_counts (center_counts),
        .center_masks  (center_masks),
        .access_count  (access_count),
        .count_valid   (count_valid),
        .grid_done     (grid_done)
    );

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== verification/roll_access_tb.sv ====
module roll_access_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import roll_grid_pkg::*;

    localparam int          DONE_LATENCY    = 2;  // Final cell to grid_done, in clock edges.
    localparam int          DONE_WAIT_LIMIT = 20;
    localparam logic [31:0] LFSR_SEED       = 32'h92aa73c9;

    logic          clk;
    logic          rst;
    logic          cell_valid;
    logic          cell_roll;
    logic          cell_row_last;
    logic          cell_grid_last;
    access_count_t access_count;
    logic          count_valid;
    logic          grid_done;

    // Grids as read from the data file.
    string grid_names[$];
    int    grid_rows[$];
    int    grid_cols[$];
    int    grid_expect[$];
    int    grid_first[$];   // Index of the grid's first cell.
    bit    cell_bits[$];

    logic [31:0] lfsr_state;
    int          total_cells;
    bit          data_loaded;
    int          pulse_total = 0;

    tb_clock clock_gen (.clk(clk));

    roll_access_top uut (
        .clk            (clk),
        .rst            (rst),
        .cell_valid     (cell_valid),
        .cell_roll      (cell_roll),
        .cell_row_last  (cell_row_last),
        .cell_grid_last (cell_grid_last),
        .access_count   (access_count),
        .count_valid    (count_valid),
        .grid_done      (grid_done)
    );

    ////////////////////////////////////////
    // Reporting and checks.
    ////////////////////////////////////////

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_count(input string test_name, input access_count_t expected,
                               input access_count_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("** Error [%s]: access_count expected %0d, actual %0d",
                               test_name, expected, actual));
        end
    endtask

    task automatic check_cycles(input string test_name, input int expected, input int actual);
        if (actual != expected) begin
            fail_run($sformatf("** Error [%s]: expected %0d, actual %0d",
                               test_name, expected, actual));
        end
    endtask

    ////////////////////////////////////////
    // Data file.
    ////////////////////////////////////////

    function automatic string trim_line(input string text);
        string s;
        s = text;
        while (s.len() > 0 && (s[s.len()-1] == "\n" || s[s.len()-1] == "\r"
                               || s[s.len()-1] == " ")) begin
            s = s.substr(0, s.len() - 2);
        end
        return s;
    endfunction

    task automatic add_row(input string line, input int line_no);
        int g;
        g = grid_names.size() - 1;
        if (line.len() > MAX_COLS || (grid_rows[g] != 0 && line.len() != grid_cols[g])) begin
            fail_run($sformatf("Row on line %0d of the data file has a bad length.", line_no));
        end
        for (int i = 0; i < line.len(); i++) begin
            if (line[i] == "@") cell_bits.push_back(1'b1);
            else if (line[i] == ".") cell_bits.push_back(1'b0);
            else fail_run($sformatf("Unknown cell character on data file line %0d.", line_no));
        end
        grid_cols[g] = line.len();
        grid_rows[g] = grid_rows[g] + 1;
        total_cells += line.len();
    endtask

    task automatic load_grids();
        int    fd;
        int    line_no;
        int    g;
        bit    open_grid;
        string line;
        fd = $fopen("verification/roll_access_testdata.txt", "r");
        if (fd == 0) fail_run("Could not open the test data file.");
        line_no     = 0;
        open_grid   = 1'b0;
        total_cells = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            line = trim_line(line);
            if (line.len() == 0 || line[0] == "#") continue;
            if (line.len() > 5 && line.substr(0, 4) == "grid ") begin
                grid_names.push_back(line.substr(5, line.len() - 1));
                grid_rows.push_back(0);
                grid_cols.push_back(0);
                grid_first.push_back(cell_bits.size());
                open_grid = 1'b1;
            end else if (line.len() > 7 && line.substr(0, 6) == "expect ") begin
                g = grid_names.size() - 1;
                if (!open_grid || grid_rows[g] < 2 || grid_rows[g] > MAX_ROWS
                    || grid_cols[g] < 2) begin
                    fail_run($sformatf("Grid ending on data file line %0d is malformed.",
                                       line_no));
                end
                grid_expect.push_back(line.substr(7, line.len() - 1).atoi());
                open_grid = 1'b0;
            end else begin
                if (!open_grid) fail_run("Data file has a row outside of a grid.");
                add_row(line, line_no);
            end
        end
        $fclose(fd);
        if (open_grid || grid_names.size() == 0) fail_run("Data file holds no complete grid.");
    endtask

    ////////////////////////////////////////
    // Stimulus.
    ////////////////////////////////////////

    // Fibonacci LFSR, taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_random_bits(input int width, output int value);
        value = 0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // Called 1 ns after a rising edge and returns at the same point of the next cycle.
    task automatic drive_cell(input bit roll, input bit row_last, input bit grid_last);
        cell_valid     = 1'b1;
        cell_roll      = roll;
        cell_row_last  = row_last;
        cell_grid_last = grid_last;
        @(posedge clk);
        #1;
        cell_valid     = 1'b0;
        cell_roll      = 1'b0;
        cell_row_last  = 1'b0;
        cell_grid_last = 1'b0;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_grid_done(output int latency);
        latency = 1;  // The final cell's own edge has passed.
        @(negedge clk);
        while (!grid_done && latency < DONE_WAIT_LIMIT) begin
            @(posedge clk);
            latency++;
            @(negedge clk);
        end
    endtask

    task automatic run_grid(input int g);
        int idx;
        int gap;
        int latency;
        int pulses_before;
        bit row_last;
        bit grid_last;
        idx           = grid_first[g];
        pulses_before = pulse_total;
        for (int r = 0; r < grid_rows[g]; r++) begin
            for (int c = 0; c < grid_cols[g]; c++) begin
                row_last  = (c == grid_cols[g] - 1);
                grid_last = row_last && (r == grid_rows[g] - 1);
                drive_cell(cell_bits[idx], row_last, grid_last);
                idx++;
                if (!grid_last) begin
                    take_random_bits(2, gap);
                    if (row_last && gap == 0) gap = 1;  // Row stage flushes the last cell.
                    idle_cycles(gap);
                end
            end
        end
        wait_grid_done(latency);
        if (!grid_done) fail_run($sformatf("No grid_done for grid %s.", grid_names[g]));
        check_cycles({grid_names[g], " done latency"}, DONE_LATENCY, latency);
        check_count(grid_names[g], access_count_t'(grid_expect[g]), access_count);
        @(posedge clk);
        #1;
        check_cycles({grid_names[g], " count_valid pulses"},
                     grid_cols[g] * (grid_rows[g] - 1), pulse_total - pulses_before);
    endtask

    always @(negedge clk) begin
        if (count_valid) pulse_total <= pulse_total + 1;
    end

    initial begin
        rst            = 1'b1;
        cell_valid     = 1'b0;
        cell_roll      = 1'b0;
        cell_row_last  = 1'b0;
        cell_grid_last = 1'b0;
        lfsr_state     = LFSR_SEED;
        data_loaded    = 1'b0;
        load_grids();
        data_loaded = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        check_count("reset", '0, access_count);
        foreach (grid_names[g]) run_grid(g);
        $display("Simulation PASSED");
        $finish;
    end

    // Watchdog, 8 cycles per cell plus slack.
    initial begin
        wait (data_loaded);
        repeat (total_cells * 8 + 100) @(posedge clk);
        fail_run($sformatf("Timeout after %0d cycles, the grids did not all complete.",
                           total_cells * 8 + 100));
    end

endmodule

// ==== verification/roll_access_testdata.txt ====
# "grid <name>" opens a grid; each following line is one row, . empty and @ a roll.
# "expect <count>" closes the grid with its number of accessible rolls.
grid sample_10x10
..@@.@@@@.
@@@.@.@.@@
@@@@@.@.@@
@.@@@@..@.
@@.@@@@.@@
.@@@@@@@.@
.@.@.@.@@@
@.@@@.@@@@
.@@@@@@@@.
@.@.@@@.@.
expect 13
grid empty_5x6
......
......
......
......
......
expect 0
grid full_4x5
@@@@@
@@@@@
@@@@@
@@@@@
expect 4
grid corner_gap_2x2
@@
@.
expect 3

// ==== roll_access.f ====
src/roll_grid_pkg.sv
src/roll_row_sum.sv
src/row_line_store.sv
src/row_window.sv
src/accessible_roll_counter.sv
src/roll_access_top.sv
verification/tb_clock.sv
verification/roll_access_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f roll_access.f --top-module roll_access_tb -o roll_access_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

./obj_dir/roll_access_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if grep -qx "Simulation PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log."
exit 1
